// ==== hw/cart_access.sv ====
`default_nettype none

module cart_access (
	input  logic                             mclk,
	input  logic                             arst_n,
	input  cart_pkg::mem_req_t               mreq,
	input  logic [cart_pkg::data_w-1:0]       rom_q,
	input  logic [cart_pkg::data_w-1:0]       bsram_q,
	output logic [cart_pkg::rom_addr_w-1:0]   rom_addr,
	output logic                             rom_ce_n,
	output logic                             rom_oe_n,
	output logic [cart_pkg::bsram_addr_w-1:0] bsram_addr,
	output logic [cart_pkg::data_w-1:0]       bsram_d,
	output logic                             bsram_ce_n,
	output logic                             bsram_oe_n,
	output logic                             bsram_we_n,
	output logic [cart_pkg::data_w-1:0]       prdata,
	output logic                             pready,
	output logic                             pslverr,
	output logic                             done
);
	import cart_pkg::*;

	logic    rom_rd;
	logic    ram_sel;
	logic    acc_valid;
	logic    acc_write;
	region_t acc_region;

	// ########################################
	// memory controls
	// ########################################
	// decoded straight off the stage 2 register so the memories sample them one edge later
	assign rom_rd  = mreq.valid && mreq.region == region_rom && !mreq.write;
	assign ram_sel = mreq.valid && mreq.region == region_bsram;

	assign rom_addr   = mreq.addr;
	assign rom_ce_n   = !rom_rd;
	assign rom_oe_n   = !rom_rd;
	assign bsram_addr = mreq.addr[bsram_addr_w-1:0];
	assign bsram_d    = mreq.wdata;
	assign bsram_ce_n = !ram_sel;
	assign bsram_oe_n = !(ram_sel && !mreq.write);
	assign bsram_we_n = !(ram_sel && mreq.write); // rom writes never reach a strobe

	// ########################################
	// response
	// ########################################
	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			acc_valid <= 1'b0;
			pready    <= 1'b0;
			pslverr   <= 1'b0;
		end else begin
			acc_valid <= mreq.valid;
			pready    <= acc_valid;
			pslverr   <= acc_valid && acc_write && acc_region == region_rom;
		end
	end

	always_ff @(posedge mclk) begin
		acc_write  <= mreq.write;
		acc_region <= mreq.region;
		if (acc_valid) begin
			case (acc_region)
				region_rom:   prdata <= rom_q;
				region_bsram: prdata <= bsram_q;
				default:      prdata <= open_bus_value;
			endcase
		end
	end

	assign done = pready; // releases the decode stage for the next access phase

endmodule

`default_nettype wire

// ==== hw/cart_bus.sv ====
`default_nettype none

module cart_bus (
	input  logic                             mclk,
	input  logic                             arst_n,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [cart_pkg::cpu_addr_w-1:0]   paddr,
	input  logic [cart_pkg::data_w-1:0]       pwdata,
	output logic [cart_pkg::data_w-1:0]       prdata,
	output logic                             pready,
	output logic                             pslverr,
	input  logic [7:0]                       rom_type,
	input  logic [cart_pkg::rom_addr_w-1:0]   rom_mask,
	input  logic [cart_pkg::bsram_addr_w-1:0] ram_mask,
	output logic [cart_pkg::rom_addr_w-1:0]   rom_addr,
	output logic                             rom_ce_n,
	output logic                             rom_oe_n,
	input  logic [cart_pkg::data_w-1:0]       rom_q,
	output logic [cart_pkg::bsram_addr_w-1:0] bsram_addr,
	output logic [cart_pkg::data_w-1:0]       bsram_d,
	input  logic [cart_pkg::data_w-1:0]       bsram_q,
	output logic                             bsram_ce_n,
	output logic                             bsram_oe_n,
	output logic                             bsram_we_n,
	output logic                             gsu_active,
	output logic                             turbo_allow
);
	import cart_pkg::*;

	cart_req_t req;
	mem_req_t  mreq;
	logic      done;

	cart_decode cart_decode_inst (
		.mclk        (mclk),
		.arst_n      (arst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.rom_type    (rom_type),
		.done        (done),
		.req         (req),
		.gsu_active  (gsu_active),
		.turbo_allow (turbo_allow)
	);

	cart_translate cart_translate_inst (
		.mclk     (mclk),
		.arst_n   (arst_n),
		.req      (req),
		.rom_mask (rom_mask),
		.ram_mask (ram_mask),
		.mreq     (mreq)
	);

	cart_access cart_access_inst (
		.mclk       (mclk),
		.arst_n     (arst_n),
		.mreq       (mreq),
		.rom_q      (rom_q),
		.bsram_q    (bsram_q),
		.rom_addr   (rom_addr),
		.rom_ce_n   (rom_ce_n),
		.rom_oe_n   (rom_oe_n),
		.bsram_addr (bsram_addr),
		.bsram_d    (bsram_d),
		.bsram_ce_n (bsram_ce_n),
		.bsram_oe_n (bsram_oe_n),
		.bsram_we_n (bsram_we_n),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.done       (done)
	);

endmodule

`default_nettype wire

// ==== hw/cart_decode.sv ====
`default_nettype none

module cart_decode (
	input  logic                           mclk,
	input  logic                           arst_n,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [cart_pkg::cpu_addr_w-1:0] paddr,
	input  logic [cart_pkg::data_w-1:0]     pwdata,
	input  logic [7:0]                     rom_type,
	input  logic                           done,
	output cart_pkg::cart_req_t            req,
	output logic                           gsu_active,
	output logic                           turbo_allow
);
	import cart_pkg::*;

	logic        busy;
	logic        capture;
	logic [7:0]  bank;
	logic [15:0] offset;
	logic        is_hirom;
	region_t     lorom_region;
	region_t     hirom_region;
	region_t     region;

	assign bank     = paddr[23:16];
	assign offset   = paddr[15:0];
	assign is_hirom = rom_type[1:0] == map_hirom;

	// the access phase is held until pready, so only its first edge is taken
	assign capture = psel && penable && !busy;

	always_comb begin
		if (offset[15])
			lorom_region = region_rom;
		else if (bank >= 8'h70 && bank <= 8'h7d)
			lorom_region = region_bsram;
		else
			lorom_region = region_open;
	end

	always_comb begin
		if (bank >= 8'hc0 || offset[15])
			hirom_region = region_rom;
		else if (bank[6:5] == 2'b01 && offset[15:13] == 3'b011) // banks 20-3f and a0-bf
			hirom_region = region_bsram;
		else
			hirom_region = region_open;
	end

	always_comb begin
		case (rom_type[1:0])
			map_hirom: region = hirom_region;
			map_lorom: region = lorom_region;
			default:   region = lorom_region; // unsupported maps fall back to lorom
		endcase
	end

	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			req  <= '0;
			busy <= 1'b0;
		end else begin
			req.valid <= capture;
			if (capture) begin
				req.write    <= pwrite;
				req.region   <= region;
				req.bank     <= bank;
				req.offset   <= offset;
				req.wdata    <= pwdata;
				req.is_hirom <= is_hirom;
				busy         <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	// ########################################
	// coprocessor flags
	// ########################################
	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			gsu_active  <= 1'b0;
			turbo_allow <= 1'b0;
		end else begin
			gsu_active  <= rom_type[7:4] == chip_gsu;
			turbo_allow <= !(rom_type[7:4] == chip_sa1 || rom_type[7:4] == chip_sdd1);
		end
	end

endmodule

`default_nettype wire

// ==== hw/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	// ########################################
	// widths
	// ########################################
	localparam int cpu_addr_w   = 24;
	localparam int rom_addr_w   = 23;
	localparam int bsram_addr_w = 20;
	localparam int data_w       = 8;

	localparam logic [data_w-1:0] open_bus_value = 8'hff; // what an unmapped read returns

	// rom_type[1:0] selects the cartridge map
	localparam logic [1:0] map_lorom = 2'd0;
	localparam logic [1:0] map_hirom = 2'd1;

	// rom_type[7:4] names the coprocessor on the cartridge
	localparam logic [3:0] chip_sdd1 = 4'h5;
	localparam logic [3:0] chip_sa1  = 4'h6;
	localparam logic [3:0] chip_gsu  = 4'h7;

	typedef enum logic [1:0] {
		region_rom,
		region_bsram,
		region_open
	} region_t;

	// ########################################
	// stage payloads
	// ########################################
	typedef struct packed {
		logic              valid;
		logic              write;
		region_t           region;
		logic [7:0]        bank;
		logic [15:0]       offset;
		logic [data_w-1:0] wdata;
		logic              is_hirom;
	} cart_req_t;

	typedef struct packed {
		logic                  valid;
		logic                  write;
		region_t               region;
		logic [rom_addr_w-1:0] addr; // bsram addresses sit in the low bits
		logic [data_w-1:0]     wdata;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== hw/cart_translate.sv ====
`default_nettype none

module cart_translate (
	input  logic                             mclk,
	input  logic                             arst_n,
	input  cart_pkg::cart_req_t              req,
	input  logic [cart_pkg::rom_addr_w-1:0]   rom_mask,
	input  logic [cart_pkg::bsram_addr_w-1:0] ram_mask,
	output cart_pkg::mem_req_t               mreq
);
	import cart_pkg::*;

	logic [rom_addr_w-1:0]   rom_phys;
	logic [bsram_addr_w-1:0] ram_phys;
	logic [rom_addr_w-1:0]   phys;

	always_comb begin
		if (req.is_hirom) begin
			rom_phys = rom_addr_w'({req.bank[5:0], req.offset});
			ram_phys = bsram_addr_w'({req.bank[4:0], req.offset[12:0]}); // 8k window per bank
		end else begin
			rom_phys = rom_addr_w'({req.bank[6:0], req.offset[14:0]});
			ram_phys = bsram_addr_w'({req.bank[3:0], req.offset[14:0]});
		end
	end

	// size masks fold addresses past the end of the chip back onto it
	always_comb begin
		if (req.region == region_rom)
			phys = rom_phys & rom_mask;
		else
			phys = {{(rom_addr_w-bsram_addr_w){1'b0}}, ram_phys & ram_mask};
	end

	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			mreq <= '0;
		end else begin
			mreq.valid <= req.valid;
			if (req.valid) begin
				mreq.write  <= req.write;
				mreq.region <= req.region;
				mreq.addr   <= phys;
				mreq.wdata  <= req.wdata;
			end
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f sim.f --top-module cart_bus_tb \
	&& ./obj_dir/Vcart_bus_tb | tee /dev/stderr | grep -q "Testbench passed" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sim.f ====
hw/cart_pkg.sv
hw/cart_decode.sv
hw/cart_translate.sv
hw/cart_access.sv
hw/cart_bus.sv
test/cart_bus_properties.sv
test/cart_bus_tb.sv

// ==== test/cart_bus_properties.sv ====
`default_nettype none

module cart_bus_properties (
	input logic mclk,
	input logic arst_n,
	input logic pready,
	input logic rom_ce_n,
	input logic bsram_ce_n
);

	int failures = 0;

	// a transfer is acknowledged for exactly one cycle
	pready_one_cycle: assert property (@(posedge mclk) disable iff (!arst_n) pready |=> !pready)
		else begin
			failures++;
			$error("pready stayed high for a second cycle");
		end

	// each access drives its memory for a single cycle
	enable_one_cycle: assert property (@(posedge mclk) disable iff (!arst_n)
			(!rom_ce_n || !bsram_ce_n) |=> (rom_ce_n && bsram_ce_n))
		else begin
			failures++;
			$error("a memory chip enable stayed low for a second cycle");
		end

	no_enable_with_pready: assert property (@(posedge mclk) disable iff (!arst_n)
			pready |-> (rom_ce_n && bsram_ce_n))
		else begin
			failures++;
			$error("a memory was enabled while a transfer completed");
		end

endmodule

bind cart_access cart_bus_properties cart_bus_properties_inst (
	.mclk       (mclk),
	.arst_n     (arst_n),
	.pready     (pready),
	.rom_ce_n   (rom_ce_n),
	.bsram_ce_n (bsram_ce_n)
);

`default_nettype wire

// ==== test/cart_bus_tb.sv ====
`default_nettype none

module cart_bus_tb;
	import cart_pkg::*;

	localparam int drive_delay    = 10;
	localparam int pready_limit   = 20;
	localparam int pready_latency = 4; // access-phase edges from E up to E+3

	logic        mclk;
	logic        arst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [23:0] paddr;
	logic [7:0]  pwdata;
	logic [7:0]  prdata;
	logic        pready;
	logic        pslverr;
	logic [7:0]  rom_type;
	logic [22:0] rom_mask;
	logic [19:0] ram_mask;
	logic [22:0] rom_addr;
	logic        rom_ce_n;
	logic        rom_oe_n;
	logic [7:0]  rom_q = 8'h00;
	logic [19:0] bsram_addr;
	logic [7:0]  bsram_d;
	logic [7:0]  bsram_q = 8'h00;
	logic        bsram_ce_n;
	logic        bsram_oe_n;
	logic        bsram_we_n;
	logic        gsu_active;
	logic        turbo_allow;

	logic [7:0]  bsram_mem [logic [19:0]];     // sparse 1 MB array where unwritten bytes read as the fill
	logic [7:0]  bsram_written [logic [19:0]]; // bytes the tests stored, by physical address
	logic [15:0] lfsr;
	int          checks;
	int          errors;

	cart_bus cart_bus_inst (.*);

	always #50 mclk = ~mclk;

	// ########################################
	// memory models
	// ########################################
	function automatic logic [7:0] rom_model(input logic [22:0] addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	function automatic logic [7:0] ram_fill(input logic [19:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {~addr[19:16], addr[19:16]};
	endfunction

	// both memories answer on the edge after an enabled read
	always @(posedge mclk) begin
		if (!rom_ce_n && !rom_oe_n)
			rom_q <= rom_model(rom_addr);
		if (!bsram_ce_n && !bsram_we_n)
			bsram_mem[bsram_addr] = bsram_d;
		if (!bsram_ce_n && !bsram_oe_n)
			bsram_q <= bsram_mem.exists(bsram_addr) ? bsram_mem[bsram_addr] : ram_fill(bsram_addr);
	end

	// ########################################
	// expected values
	// ########################################
	function automatic logic [19:0] ram_phys(input logic [23:0] addr, input logic hirom);
		if (hirom)
			return {2'b00, addr[20:16], addr[12:0]}; // 8k per bank
		return {1'b0, addr[19:16], addr[14:0]};
	endfunction

	function automatic logic [7:0] expected_read(input logic [23:0] addr);
		logic        hirom;
		logic [7:0]  bank;
		logic [15:0] offset;
		logic [19:0] ram_at;
		hirom  = rom_type[1:0] == map_hirom;
		bank   = addr[23:16];
		offset = addr[15:0];
		ram_at = ram_phys(addr, hirom) & ram_mask;
		if (offset >= 16'h8000 || (hirom && bank >= 8'hc0)) begin
			if (hirom)
				return rom_model({1'b0, addr[21:0]} & rom_mask);
			return rom_model({1'b0, addr[22:16], addr[14:0]} & rom_mask);
		end
		if (hirom ? (bank[6:0] >= 7'h20 && bank[6:0] <= 7'h3f && offset >= 16'h6000)
				: (bank >= 8'h70 && bank <= 8'h7d))
			return bsram_written.exists(ram_at) ? bsram_written[ram_at] : ram_fill(ram_at);
		return 8'hff; // open bus
	endfunction

	// 16-bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic draw_addr(output logic [23:0] value);
		int i;
		value = '0;
		for (i = 0; i < 24; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[22:0], lfsr[0]};
		end
	endtask

	// ########################################
	// checking and bus tasks
	// ########################################
	task automatic compare(input string test, input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic apb_transfer(input string test, input logic write, input logic [23:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		int waited;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge mclk);
		#drive_delay;
		penable = 1'b1;
		waited  = 0;
		while (!pready && waited < pready_limit) begin
			@(posedge mclk);
			#drive_delay;
			waited++;
		end
		if (!pready) begin
			errors++;
			$display("%s: no pready within %0d cycles of the access phase", test, pready_limit);
		end else begin
			compare(test, 8'(pready_latency), 8'(waited));
		end
		rdata   = prdata;
		err     = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_check(input string test, input logic [23:0] addr);
		logic [7:0] data;
		logic       err;
		apb_transfer(test, 1'b0, addr, 8'h00, data, err);
		compare(test, expected_read(addr), data);
		compare(test, 8'h00, {7'd0, err});
	endtask

	task automatic ram_store(input string test, input logic [23:0] addr, input logic [7:0] data);
		logic [7:0] rdata;
		logic       err;
		apb_transfer(test, 1'b1, addr, data, rdata, err);
		compare(test, 8'h00, {7'd0, err});
		bsram_written[ram_phys(addr, rom_type[1:0] == map_hirom) & ram_mask] = data;
	endtask

	task automatic configure(input logic [1:0] map, input logic [22:0] rmask,
			input logic [19:0] smask);
		rom_type = {4'h0, 2'b00, map};
		rom_mask = rmask;
		ram_mask = smask;
	endtask

	// ########################################
	// directed tests
	// ########################################
	task automatic lorom_rom_reads();
		int start;
		start = errors;
		configure(map_lorom, 23'h7fffff, 20'hfffff);
		read_check("lorom_rom", 24'h008000);
		read_check("lorom_rom", 24'h01ffff);
		read_check("lorom_rom", 24'h3f9abc);
		read_check("lorom_rom", 24'h80c123);
		read_check("lorom_rom", 24'hfe8765);
		$display("lorom_rom finished with %0d errors", errors - start);
	endtask

	task automatic hirom_masked_reads();
		int start;
		start = errors;
		configure(map_hirom, 23'h0fffff, 20'hfffff);
		read_check("hirom_rom", 24'hc01234);
		read_check("hirom_rom", 24'hd5abcd);
		read_check("hirom_rom", 24'he30000);
		read_check("hirom_rom", 24'hffffff);
		read_check("hirom_rom", 24'hc75a5a);
		$display("hirom_rom finished with %0d errors", errors - start);
	endtask

	task automatic bsram_write_read();
		int         start;
		logic [7:0] data;
		logic       err;
		start = errors;
		configure(map_lorom, 23'h7fffff, 20'h07fff);
		ram_store("bsram_lorom", 24'h700123, 8'ha5);
		read_check("bsram_lorom", 24'h700123);
		ram_store("bsram_lorom", 24'h710123, 8'h3c); // bank bit 0 lands above the 32k mask
		apb_transfer("bsram_lorom_alias", 1'b0, 24'h700123, 8'h00, data, err);
		compare("bsram_lorom_alias", 8'h3c, data);
		configure(map_hirom, 23'h7fffff, 20'h01fff);
		ram_store("bsram_hirom", 24'h206010, 8'h5a);
		read_check("bsram_hirom", 24'h206010);
		ram_store("bsram_hirom", 24'ha16010, 8'hc3);
		apb_transfer("bsram_hirom_alias", 1'b0, 24'h206010, 8'h00, data, err);
		compare("bsram_hirom_alias", 8'hc3, data);
		$display("bsram finished with %0d errors", errors - start);
	endtask

	task automatic open_bus_and_rom_write();
		int         start;
		logic [7:0] data;
		logic       err;
		start = errors;
		configure(map_lorom, 23'h7fffff, 20'hfffff);
		apb_transfer("open_bus", 1'b0, 24'h002000, 8'h00, data, err);
		compare("open_bus", 8'hff, data);
		compare("open_bus", 8'h00, {7'd0, err});
		apb_transfer("rom_write", 1'b1, 24'h018000, 8'h5a, data, err);
		compare("rom_write", 8'h01, {7'd0, err});
		read_check("rom_write", 24'h018000);
		// bank 71 offset 0 shares the physical address bits of the rejected write
		read_check("rom_write", 24'h710000);
		$display("open_and_rom_write finished with %0d errors", errors - start);
	endtask

	task automatic flags_check(input logic [3:0] chip, input logic gsu, input logic turbo);
		rom_type = {chip, 2'b00, map_lorom};
		@(posedge mclk);
		#drive_delay;
		compare("chip_flags", {6'd0, gsu, turbo}, {6'd0, gsu_active, turbo_allow});
	endtask

	task automatic chip_flag_codes();
		int start;
		start = errors;
		flags_check(chip_gsu, 1'b1, 1'b1);
		flags_check(chip_sa1, 1'b0, 1'b0);
		flags_check(chip_sdd1, 1'b0, 1'b0);
		flags_check(4'h0, 1'b0, 1'b1);
		flags_check(4'h3, 1'b0, 1'b1);
		$display("chip_flags finished with %0d errors", errors - start);
	endtask

	task automatic random_reads();
		int          start;
		int          n;
		logic [23:0] addr;
		start = errors;
		for (n = 0; n < 40; n++) begin
			configure(n < 20 ? map_lorom : map_hirom, 23'h1fffff, 20'h03fff);
			draw_addr(addr);
			read_check("random_read", addr);
		end
		$display("random_reads finished with %0d errors", errors - start);
	endtask

	initial begin
		mclk     = 1'b0;
		arst_n   = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		rom_type = '0;
		rom_mask = '1;
		ram_mask = '1;
		lfsr     = 16'd21139;
		checks   = 0;
		errors   = 0;
		repeat (5) @(posedge mclk);
		#drive_delay;
		arst_n = 1'b1;
		lorom_rom_reads();
		hirom_masked_reads();
		bsram_write_read();
		open_bus_and_rom_write();
		chip_flag_codes();
		random_reads();
		errors += cart_bus_inst.cart_access_inst.cart_bus_properties_inst.failures;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
